//--- verilog/host_pkg.sv
package host_pkg;

    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    typedef enum logic [1:0] {
        ST_STOPPED = 2'd0,
        ST_RUNNING = 2'd1,
        ST_HALTED  = 2'd2
    } run_state_t;

    typedef enum logic [1:0] {
        C_NONE    = 2'd0,
        C_EBREAK  = 2'd1,
        C_ECALL   = 2'd2,
        C_ILLEGAL = 2'd3
    } halt_cause_t;

    // windows selected by paddr[11:10]
    localparam logic [1:0] WIN_IMEM = 2'd0;
    localparam logic [1:0] WIN_DMEM = 2'd1;
    localparam logic [1:0] WIN_CTRL = 2'd2;
    localparam logic [1:0] WIN_REGS = 2'd3;

    // control registers, paddr[4:2]
    localparam logic [2:0] REG_CTRL    = 3'd0;
    localparam logic [2:0] REG_STATUS  = 3'd1;
    localparam logic [2:0] REG_PC      = 3'd2;
    localparam logic [2:0] REG_RETIRED = 3'd3;

endpackage

//--- verilog/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    localparam logic [2:0] F3_ADD  = 3'b000; // addi, add, sub
    localparam logic [2:0] F3_SW   = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_SR   = 3'b101; // only srai here
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, srai

    // system instructions are matched on the whole word
    localparam inst_t INST_ECALL  = 32'h0000_0073;
    localparam inst_t INST_EBREAK = 32'h0010_0073;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLTU,
        ALU_SRA,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {
        K_I,
        K_U,
        K_R,
        K_S,
        K_SYS,
        K_ILLEGAL
    } inst_kind_t;

    typedef struct packed {
        reg_idx_t              rd;
        reg_idx_t              rs1;
        reg_idx_t              rs2;
        xlen_t                 imm;
        alu_op_t               alu_op;
        inst_kind_t            kind;
        logic                  use_pc;  // auipc
        logic                  zero_a;  // lui
        logic                  use_imm;
        logic                  reg_we;
        logic                  mem_we;
        logic                  halt;
        host_pkg::halt_cause_t cause;
    } decoded_t;

endpackage

//--- verilog/inst_decode.sv
`timescale 1ns/10ps

module inst_decode
    import rv_isa_pkg::*;
    import host_pkg::*;
(
    input  inst_t    inst,
    output decoded_t dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_u;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        dec        = '0;
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];
        dec.alu_op = ALU_ADD;
        dec.kind   = K_ILLEGAL;
        dec.cause  = C_NONE;

        case (opcode)
            OP_IMM: begin
                dec.kind    = K_I;
                dec.imm     = imm_i;
                dec.use_imm = 1'b1;
                dec.reg_we  = 1'b1;
                case (funct3)
                    F3_ADD:  dec.alu_op = ALU_ADD;
                    F3_SLTU: dec.alu_op = ALU_SLTU;
                    F3_AND:  dec.alu_op = ALU_AND;
                    F3_SR: begin
                        dec.alu_op = ALU_SRA;
                        if (funct7 != F7_ALT)
                            dec.kind = K_ILLEGAL; // srli or bad shamt bits
                    end
                    default: dec.kind = K_ILLEGAL;
                endcase
            end
            OP_LUI: begin
                dec.kind    = K_U;
                dec.rs1     = '0;
                dec.imm     = imm_u;
                dec.zero_a  = 1'b1;
                dec.use_imm = 1'b1;
                dec.alu_op  = ALU_PASS_B;
                dec.reg_we  = 1'b1;
            end
            OP_AUIPC: begin
                dec.kind    = K_U;
                dec.imm     = imm_u;
                dec.use_pc  = 1'b1;
                dec.use_imm = 1'b1;
                dec.reg_we  = 1'b1;
            end
            OP_REG: begin
                dec.kind   = K_R;
                dec.reg_we = 1'b1;
                if (funct3 == F3_ADD && funct7 == F7_BASE)
                    dec.alu_op = ALU_ADD;
                else if (funct3 == F3_ADD && funct7 == F7_ALT)
                    dec.alu_op = ALU_SUB;
                else
                    dec.kind = K_ILLEGAL;
            end
            OP_STORE: begin
                if (funct3 == F3_SW) begin // sb and sh fall through as illegal
                    dec.kind    = K_S;
                    dec.imm     = imm_s;
                    dec.use_imm = 1'b1;
                    dec.mem_we  = 1'b1;
                end
            end
            OP_SYSTEM: begin
                dec.rs1 = '0;
                if (inst == INST_ECALL) begin
                    dec.kind  = K_SYS;
                    dec.halt  = 1'b1;
                    dec.cause = C_ECALL;
                end else if (inst == INST_EBREAK) begin
                    dec.kind  = K_SYS;
                    dec.halt  = 1'b1;
                    dec.cause = C_EBREAK;
                end
            end
            default: dec.kind = K_ILLEGAL;
        endcase

        // anything unrecognised stops the core without side effects
        if (dec.kind == K_ILLEGAL) begin
            dec.halt   = 1'b1;
            dec.cause  = C_ILLEGAL;
            dec.reg_we = 1'b0;
            dec.mem_we = 1'b0;
        end
        if (dec.rd == '0)
            dec.reg_we = 1'b0;
    end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/10ps

module reg_file
    import rv_isa_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t host_idx,
    output xlen_t    rs1_data,
    output xlen_t    rs2_data,
    output xlen_t    host_data,
    input  logic     we,
    input  reg_idx_t rd,
    input  xlen_t    wdata
);

    xlen_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data  = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data  = (rs2 == '0) ? '0 : regs[rs2];
    assign host_data = (host_idx == '0) ? '0 : regs[host_idx];

endmodule

//--- verilog/exec_unit.sv
`timescale 1ns/10ps

module exec_unit
    import rv_isa_pkg::*;
(
    input  decoded_t dec,
    input  xlen_t    pc,
    input  xlen_t    rs1_data,
    input  xlen_t    rs2_data,
    output xlen_t    result,
    output xlen_t    next_pc,
    output xlen_t    st_addr,
    output xlen_t    st_data
);

    xlen_t op_a;
    xlen_t op_b;

    // operand a: zero for lui, pc for auipc
    always_comb begin
        if (dec.zero_a)
            op_a = '0;
        else if (dec.use_pc)
            op_a = pc;
        else
            op_a = rs1_data;
    end

    assign op_b = dec.use_imm ? dec.imm : rs2_data;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLTU:   result = {31'b0, (op_a < op_b)}; // unsigned compare
            ALU_SRA:    result = $signed(op_a) >>> dec.imm[4:0];
            ALU_AND:    result = op_a & op_b;
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    // sw only, full word
    assign st_addr = rs1_data + dec.imm;
    assign st_data = rs2_data;

    assign next_pc = pc + 32'd4; // no branches in this subset

endmodule

//--- verilog/host_ctrl.sv
`timescale 1ns/10ps

module host_ctrl
    import rv_isa_pkg::*;
    import host_pkg::*;
#(
    parameter int IMEM_DEPTH = 64, // power of two, index wraps
    parameter int DMEM_DEPTH = 64
) (
    input  logic        clk,
    input  logic        rst_n,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    input  xlen_t       pc,
    output inst_t       inst,
    input  logic        halt,
    input  halt_cause_t cause,
    input  logic        mem_we,
    input  xlen_t       st_addr,
    input  xlen_t       st_data,
    output reg_idx_t    reg_idx,
    input  xlen_t       reg_data,
    output logic        running,
    output logic        start
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    inst_t imem [IMEM_DEPTH];
    xlen_t dmem [DMEM_DEPTH];

    run_state_t  state;
    halt_cause_t cause_q;
    xlen_t       retired;

    logic               access;
    logic [1:0]         win;
    logic [2:0]         creg;
    logic [IMEM_AW-1:0] h_iidx;
    logic [DMEM_AW-1:0] h_didx;
    logic               wr_err;
    logic               wr_ok;
    logic               core_st;
    apb_data_t          rdata;

    assign access = apb_req.psel && apb_req.penable;
    assign win    = apb_req.paddr[11:10];
    assign creg   = apb_req.paddr[4:2];
    assign h_iidx = apb_req.paddr[IMEM_AW+1:2];
    assign h_didx = apb_req.paddr[DMEM_AW+1:2];

    // rejected writes: register window, read-only control regs,
    // memories while a program runs
    always_comb begin
        wr_err = 1'b0;
        if (apb_req.pwrite) begin
            case (win)
                WIN_CTRL: wr_err = (creg != REG_CTRL);
                WIN_REGS: wr_err = 1'b1;
                default:  wr_err = (state == ST_RUNNING);
            endcase
        end
    end

    assign wr_ok = access && apb_req.pwrite && !wr_err;
    assign start = wr_ok && win == WIN_CTRL && creg == REG_CTRL
                   && apb_req.pwdata[0] && state != ST_RUNNING;

    assign running = (state == ST_RUNNING);
    assign core_st = running && mem_we && !halt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_STOPPED;
            cause_q <= C_NONE;
            retired <= '0;
        end else if (start) begin
            state   <= ST_RUNNING;
            cause_q <= C_NONE;
            retired <= '0;
        end else if (running) begin
            if (halt) begin
                state   <= ST_HALTED;
                cause_q <= cause;
            end else begin
                retired <= retired + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok && win == WIN_IMEM)
            imem[h_iidx] <= apb_req.pwdata;
    end

    // host writes are refused while running, so the two never collide
    always_ff @(posedge clk) begin
        if (core_st)
            dmem[st_addr[DMEM_AW+1:2]] <= st_data;
        else if (wr_ok && win == WIN_DMEM)
            dmem[h_didx] <= apb_req.pwdata;
    end

    assign inst    = imem[pc[IMEM_AW+1:2]];
    assign reg_idx = apb_req.paddr[6:2];

    always_comb begin
        rdata = '0;
        case (win)
            WIN_IMEM: rdata = imem[h_iidx];
            WIN_DMEM: rdata = dmem[h_didx];
            WIN_CTRL: begin
                case (creg)
                    REG_STATUS:  rdata = {26'b0, cause_q, 2'b00, state};
                    REG_PC:      rdata = pc;
                    REG_RETIRED: rdata = retired;
                    default:     rdata = '0; // CTRL reads back zero
                endcase
            end
            WIN_REGS: rdata = reg_data;
            default:  rdata = '0;
        endcase
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1; // zero wait states
    assign apb_rsp.pslverr = access && wr_err;

endmodule

//--- verilog/mini_core.sv
`timescale 1ns/10ps

module mini_core
    import rv_isa_pkg::*;
    import host_pkg::*;
#(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic     clk,
    input  logic     rst_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    xlen_t    pc;
    xlen_t    next_pc;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    result;
    xlen_t    st_addr;
    xlen_t    st_data;
    xlen_t    host_rdata;
    inst_t    inst;
    decoded_t dec;
    reg_idx_t host_idx;
    logic     running;
    logic     start;
    logic     reg_we;

    // a halting instruction leaves pc pointing at itself
    always_ff @(posedge clk) begin
        if (!rst_n)
            pc <= '0;
        else if (start)
            pc <= '0;
        else if (running && !dec.halt)
            pc <= next_pc;
    end

    assign reg_we = running && !dec.halt && dec.reg_we;

    inst_decode decode_i (
        .inst (inst),
        .dec  (dec)
    );

    reg_file rf_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1       (dec.rs1),
        .rs2       (dec.rs2),
        .host_idx  (host_idx),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .host_data (host_rdata),
        .we        (reg_we),
        .rd        (dec.rd),
        .wdata     (result)
    );

    exec_unit exec_i (
        .dec      (dec),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (result),
        .next_pc  (next_pc),
        .st_addr  (st_addr),
        .st_data  (st_data)
    );

    host_ctrl #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) host_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .pc       (pc),
        .inst     (inst),
        .halt     (dec.halt),
        .cause    (dec.cause),
        .mem_we   (dec.mem_we),
        .st_addr  (st_addr),
        .st_data  (st_data),
        .reg_idx  (host_idx),
        .reg_data (host_rdata),
        .running  (running),
        .start    (start)
    );

endmodule

//--- tb/mini_core_tb.sv
`timescale 1ns/10ps

module mini_core_tb
    import host_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int NUM_PROGS    = 8;
    localparam int MAX_INST     = 24;
    localparam int DMEM_WORDS   = 64;
    localparam int ILLEGAL_PROG = 5; // this program ends in sh
    localparam int MAX_POLLS    = 20;
    // each APB transfer takes 3 clocks
    localparam int XFER_CLKS   = 3;
    localparam int CYCLE_LIMIT = NUM_PROGS * (MAX_INST + XFER_CLKS * (40 + 80) + 50);

    logic     clk;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    logic [15:0] lfsr_q;
    int          errors;
    int          checks;
    int          cycles = 0;

    logic [31:0] m_regs [32]; // reference register file
    logic [31:0] m_mem [DMEM_WORDS];
    logic        touched [DMEM_WORDS]; // words stored by the current program
    logic [31:0] prog [MAX_INST+1];

    mini_core #(
        .IMEM_DEPTH (64),
        .DMEM_DEPTH (DMEM_WORDS)
    ) dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout, no end of test after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // 16-bit fibonacci lfsr with taps 16 14 13 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[30:0], lfsr_bit()};
        return r;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [11:0] imem_addr(input int i);
        return {2'b00, 8'(i), 2'b00};
    endfunction

    function automatic logic [11:0] dmem_addr(input int i);
        return {2'b01, 8'(i), 2'b00};
    endfunction

    function automatic logic [11:0] ctrl_addr(input int i);
        return {2'b10, 5'b0, 3'(i), 2'b00};
    endfunction

    function automatic logic [11:0] reg_addr(input int i);
        return {2'b11, 3'b0, 5'(i), 2'b00};
    endfunction

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s got %h expected %h", $time, name, act, exp);
        end
    endtask

    // setup, access, then idle on the following falling edges
    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic err);
        @(negedge clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(negedge clk);
        apb_req.penable = 1'b1;
        #5;
        err = apb_rsp.pslverr; // well before the access edge
        check("pready on write", {31'b0, apb_rsp.pready}, 32'd1);
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
        @(negedge clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'd0};
        @(negedge clk);
        apb_req.penable = 1'b1;
        #5;
        data = apb_rsp.prdata;
        check("pready on read", {31'b0, apb_rsp.pready}, 32'd1);
        @(negedge clk);
        apb_req = '0;
    endtask

    // builds one program and runs it on the model at the same time
    task automatic gen_program(input int p, output int n, output logic [1:0] cause);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [11:0] imm;
        logic [19:0] upper;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  kind;
        n = int'(rand_bits(5) % 24) + 1;
        for (int i = 0; i < n; i++) begin
            rd = 5'(rand_bits(3)); // x0..x7 only
            rs1 = 5'(rand_bits(3));
            rs2 = 5'(rand_bits(3));
            imm = 12'(rand_bits(12));
            upper = 20'(rand_bits(20));
            kind = 3'(rand_bits(3));
            a = m_regs[rs1];
            b = m_regs[rs2];
            case (kind)
                3'd0: begin // addi
                    prog[i] = {imm, rs1, 3'b000, rd, 7'b0010011};
                    v = a + sext12(imm);
                end
                3'd1: begin // sltiu
                    prog[i] = {imm, rs1, 3'b011, rd, 7'b0010011};
                    v = (a < sext12(imm)) ? 32'd1 : 32'd0;
                end
                3'd2: begin // srai
                    prog[i] = {7'b0100000, imm[4:0], rs1, 3'b101, rd, 7'b0010011};
                    v = $signed(a) >>> imm[4:0];
                end
                3'd3: begin // andi
                    prog[i] = {imm, rs1, 3'b111, rd, 7'b0010011};
                    v = a & sext12(imm);
                end
                3'd4: begin // lui
                    prog[i] = {upper, rd, 7'b0110111};
                    v = {upper, 12'b0};
                end
                3'd5: begin // auipc relative to a program at 0
                    prog[i] = {upper, rd, 7'b0010111};
                    v = 32'(4 * i) + {upper, 12'b0};
                end
                3'd6: begin // add or sub
                    prog[i] = {imm[0] ? 7'b0100000 : 7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
                    v = imm[0] ? a - b : a + b;
                end
                default: begin // sw with wrapping word index
                    prog[i] = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
                    v = a + sext12(imm);
                    m_mem[v[7:2]] = b;
                    touched[v[7:2]] = 1'b1;
                end
            endcase
            if (kind != 3'd7 && rd != 5'd0)
                m_regs[rd] = v;
        end
        if (p == ILLEGAL_PROG) begin
            prog[n] = {7'b0, 5'd1, 5'd2, 3'b001, 5'd0, 7'b0100011}; // sh
            cause = 2'd3;
        end else if (lfsr_bit()) begin
            prog[n] = 32'h0010_0073; // ebreak
            cause = 2'd1;
        end else begin
            prog[n] = 32'h0000_0073; // ecall
            cause = 2'd2;
        end
    endtask

    task automatic protection_checks(input int halt_pc);
        logic        err;
        logic [31:0] data;
        apb_write(ctrl_addr(2), 32'h0000_0abc, err);
        check("pslverr on PC write", {31'b0, err}, 32'd1);
        apb_read(ctrl_addr(2), data);
        check("PC after refused write", data, 32'(halt_pc));
        apb_write(reg_addr(1), 32'hdead_beef, err);
        check("pslverr on x1 write", {31'b0, err}, 32'd1);
        apb_read(reg_addr(1), data);
        check("x1 after refused write", data, m_regs[1]);
    endtask

    initial begin
        int          n;
        int          polls;
        logic [1:0]  cause;
        logic        err;
        logic [31:0] rd_data;
        lfsr_q = 16'd19;
        errors = 0;
        checks = 0;
        apb_req = '0;
        rst_n = 1'b0;
        for (int r = 0; r < 32; r++)
            m_regs[r] = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        apb_read(ctrl_addr(1), rd_data);
        check("STATUS after reset", rd_data, 32'd0);
        apb_read(ctrl_addr(2), rd_data);
        check("PC after reset", rd_data, 32'd0);
        apb_read(ctrl_addr(3), rd_data);
        check("RETIRED after reset", rd_data, 32'd0);

        for (int p = 0; p < NUM_PROGS; p++) begin
            for (int w = 0; w < DMEM_WORDS; w++)
                touched[w] = 1'b0;
            gen_program(p, n, cause);
            for (int i = 0; i <= n; i++) begin
                apb_write(imem_addr(i), prog[i], err);
                check("pslverr on imem write", {31'b0, err}, 32'd0);
            end
            if (p == 0) begin
                for (int i = 0; i <= n; i++) begin
                    apb_read(imem_addr(i), rd_data);
                    check($sformatf("imem[%0d]", i), rd_data, prog[i]);
                end
            end
            apb_write(ctrl_addr(0), 32'd1, err);
            check("pslverr on start", {31'b0, err}, 32'd0);

            polls = 0;
            rd_data = '0;
            while (rd_data[1:0] != 2'd2 && polls < MAX_POLLS) begin
                apb_read(ctrl_addr(1), rd_data);
                polls++;
            end
            if (rd_data[1:0] != 2'd2) begin
                errors++;
                $display("program %0d did not halt within %0d status reads", p, MAX_POLLS);
            end
            check("STATUS", rd_data, {26'b0, cause, 2'b00, 2'd2});
            apb_read(ctrl_addr(2), rd_data);
            check("PC", rd_data, 32'(4 * n)); // the halting instruction
            apb_read(ctrl_addr(3), rd_data);
            check("RETIRED", rd_data, 32'(n));

            for (int r = 0; r < 8; r++) begin
                apb_read(reg_addr(r), rd_data);
                check($sformatf("x%0d", r), rd_data, m_regs[r]);
            end
            for (int w = 0; w < DMEM_WORDS; w++) begin
                if (touched[w]) begin
                    apb_read(dmem_addr(w), rd_data);
                    check($sformatf("dmem[%0d]", w), rd_data, m_mem[w]);
                end
            end
            if (p == 0)
                protection_checks(4 * n);
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- mini_core.f
verilog/host_pkg.sv
verilog/rv_isa_pkg.sv
verilog/inst_decode.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/host_ctrl.sv
verilog/mini_core.sv
tb/mini_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -j 0 \
    --top-module mini_core_tb -f mini_core.f -o mini_core_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/mini_core_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Simulation completed successfully$"; then
    exit 0
fi
exit 1
